//--- Makefile
TOP = scratchpad_2rw_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f scratchpad_2rw_top.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/scratch_params.svh
`ifndef SCRATCH_PARAMS_SVH
`define SCRATCH_PARAMS_SVH

// Word width in bits
`define SCR_WIDTH_P 32

// Number of words in the scratchpad
`define SCR_ELS_P 64

// Bits per memory slice which divides SCR_WIDTH_P
`define SCR_SLICE_P 8

`endif

//--- common/scratch_pkg.sv
`default_nettype none

`include "scratch_params.svh"

package scratch_pkg;

  // Address width follows the word count
  localparam int scr_addr_width_lc = $clog2(`SCR_ELS_P);

  // Number of narrow slices making up one word
  localparam int scr_slices_lc = `SCR_WIDTH_P / `SCR_SLICE_P;

  // One data word
  typedef logic [`SCR_WIDTH_P-1:0] scr_word_t;

  // Per-bit write mask where 1 writes the bit
  typedef logic [`SCR_WIDTH_P-1:0] scr_mask_t;

  // Word address
  typedef logic [scr_addr_width_lc-1:0] scr_addr_t;

endpackage

`default_nettype wire

//--- mem/mem_2rw_sync.sv
`default_nettype none

`include "scratch_params.svh"

module mem_2rw_sync
  import scratch_pkg::*;
#(
  parameter int width_p = `SCR_SLICE_P,
  parameter int els_p   = `SCR_ELS_P
)
(
  input  wire logic               clk_i,

  input  wire logic               a_v_i,
  input  wire logic               a_w_i,
  input  wire scr_addr_t          a_addr_i,
  input  wire logic [width_p-1:0] a_data_i,
  input  wire logic [width_p-1:0] a_w_mask_i,
  output logic      [width_p-1:0] a_data_o,

  input  wire logic               b_v_i,
  input  wire logic               b_w_i,
  input  wire scr_addr_t          b_addr_i,
  input  wire logic [width_p-1:0] b_data_i,
  input  wire logic [width_p-1:0] b_w_mask_i,
  output logic      [width_p-1:0] b_data_o
);

  logic [width_p-1:0] mem_r [els_p]; // Powers up undefined

  // Reads see the contents before this edge's writes
  always_ff @(posedge clk_i)
  begin
    if (a_v_i & ~a_w_i)
      a_data_o <= mem_r[a_addr_i];
    if (b_v_i & ~b_w_i)
      b_data_o <= mem_r[b_addr_i];
  end

  // Port B is applied last, so its set bits win on a collision
  always_ff @(posedge clk_i)
  begin
    if (a_v_i & a_w_i)
    begin
      for (int i = 0; i < width_p; i++)
        if (a_w_mask_i[i])
          mem_r[a_addr_i][i] <= a_data_i[i];
    end
    if (b_v_i & b_w_i)
    begin
      for (int i = 0; i < width_p; i++)
        if (b_w_mask_i[i])
          mem_r[b_addr_i][i] <= b_data_i[i];
    end
  end

  a_addr_range: assert property (@(posedge clk_i) a_v_i |-> (a_addr_i < els_p))
    else $error("mem_2rw_sync: port A address out of range");

  b_addr_range: assert property (@(posedge clk_i) b_v_i |-> (b_addr_i < els_p))
    else $error("mem_2rw_sync: port B address out of range");

endmodule

`default_nettype wire

//--- mem/mem_2rw_sync_mask_write_bit.sv
`default_nettype none

`include "scratch_params.svh"

module mem_2rw_sync_mask_write_bit
  import scratch_pkg::*;
(
  input  wire logic      clk_i,

  input  wire logic      a_v_i,
  input  wire logic      a_w_i,
  input  wire scr_addr_t a_addr_i,
  input  wire scr_word_t a_data_i,
  input  wire scr_mask_t a_w_mask_i,
  output scr_word_t      a_data_o,

  input  wire logic      b_v_i,
  input  wire logic      b_w_i,
  input  wire scr_addr_t b_addr_i,
  input  wire scr_word_t b_data_i,
  input  wire scr_mask_t b_w_mask_i,
  output scr_word_t      b_data_o
);

  if ((`SCR_WIDTH_P % `SCR_SLICE_P) != 0)
  begin : g_bad_slice
    $error("SCR_WIDTH_P must be a multiple of SCR_SLICE_P");
  end

  for (genvar s = 0; s < scr_slices_lc; s++)
  begin : g_slice
    logic a_any; // Some mask bit set in this slice
    logic b_any;

    assign a_any = |a_w_mask_i[s*`SCR_SLICE_P +: `SCR_SLICE_P];
    assign b_any = |b_w_mask_i[s*`SCR_SLICE_P +: `SCR_SLICE_P];

    mem_2rw_sync #(
      .width_p (`SCR_SLICE_P),
      .els_p   (`SCR_ELS_P)
    ) u_mem_2rw_sync (
      .clk_i      (clk_i),
      .a_v_i      (a_v_i & (a_w_i ? a_any : 1'b1)), // Idle slice stays off
      .a_w_i      (a_w_i & a_any),
      .a_addr_i   (a_addr_i),
      .a_data_i   (a_data_i[s*`SCR_SLICE_P +: `SCR_SLICE_P]),
      .a_w_mask_i (a_w_mask_i[s*`SCR_SLICE_P +: `SCR_SLICE_P]),
      .a_data_o   (a_data_o[s*`SCR_SLICE_P +: `SCR_SLICE_P]),
      .b_v_i      (b_v_i & (b_w_i ? b_any : 1'b1)),
      .b_w_i      (b_w_i & b_any),
      .b_addr_i   (b_addr_i),
      .b_data_i   (b_data_i[s*`SCR_SLICE_P +: `SCR_SLICE_P]),
      .b_w_mask_i (b_w_mask_i[s*`SCR_SLICE_P +: `SCR_SLICE_P]),
      .b_data_o   (b_data_o[s*`SCR_SLICE_P +: `SCR_SLICE_P])
    );
  end

endmodule

`default_nettype wire

//--- scratchpad_2rw_top.f
+incdir+common
common/scratch_pkg.sv
mem/mem_2rw_sync.sv
mem/mem_2rw_sync_mask_write_bit.sv
source/port_request_stage.sv
source/read_response_stage.sv
source/scratchpad_2rw_top.sv
testbench/scratchpad_2rw_tb.sv

//--- source/port_request_stage.sv
`default_nettype none

`include "scratch_params.svh"

module port_request_stage
  import scratch_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  input  wire logic      v_i,
  input  wire logic      w_i,
  input  wire scr_addr_t addr_i,
  input  wire scr_word_t data_i,
  input  wire scr_mask_t w_mask_i,

  output logic           v_o,
  output logic           w_o,
  output scr_addr_t      addr_o,
  output scr_word_t      data_o,
  output scr_mask_t      w_mask_o,
  output logic           rd_pend_o
);

  logic w_drop; // Write that would change no bit

  assign w_drop = w_i & ~(|w_mask_i);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      v_o       <= 1'b0;
      w_o       <= 1'b0;
      rd_pend_o <= 1'b0;
    end
    else
    begin
      v_o       <= v_i & ~w_drop;
      w_o       <= w_i;
      rd_pend_o <= v_o & ~w_o; // Lines up with memory read data
    end
  end

  always_ff @(posedge clk_i)
  begin
    addr_o   <= addr_i;
    data_o   <= data_i;
    w_mask_o <= w_mask_i;
  end

  a_v_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(v_i))
    else $error("port_request_stage: v_i unknown after reset");

endmodule

`default_nettype wire

//--- source/read_response_stage.sv
`default_nettype none

`include "scratch_params.svh"

module read_response_stage
  import scratch_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  input  wire logic      rd_pend_i,
  input  wire scr_word_t rd_data_i,

  output logic           rd_v_o,
  output scr_word_t      rd_data_o
);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_v_o    <= 1'b0;
      rd_data_o <= '0;
    end
    else
    begin
      rd_v_o <= rd_pend_i; // One pulse per read
      if (rd_pend_i)
        rd_data_o <= rd_data_i; // Hold last read otherwise
    end
  end

  a_rd_v_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(rd_v_o))
    else $error("read_response_stage: rd_v_o unknown after reset");

endmodule

`default_nettype wire

//--- source/scratchpad_2rw_top.sv
`default_nettype none

`include "scratch_params.svh"

module scratchpad_2rw_top
  import scratch_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  input  wire logic      a_v_i,
  input  wire logic      a_w_i,
  input  wire scr_addr_t a_addr_i,
  input  wire scr_word_t a_data_i,
  input  wire scr_mask_t a_w_mask_i,
  output logic           a_rd_v_o,
  output scr_word_t      a_rd_data_o,

  input  wire logic      b_v_i,
  input  wire logic      b_w_i,
  input  wire scr_addr_t b_addr_i,
  input  wire scr_word_t b_data_i,
  input  wire scr_mask_t b_w_mask_i,
  output logic           b_rd_v_o,
  output scr_word_t      b_rd_data_o
);

  logic      a_req_v;
  logic      a_req_w;
  scr_addr_t a_req_addr;
  scr_word_t a_req_data;
  scr_mask_t a_req_mask;
  logic      a_rd_pend;
  scr_word_t a_mem_data;

  logic      b_req_v;
  logic      b_req_w;
  scr_addr_t b_req_addr;
  scr_word_t b_req_data;
  scr_mask_t b_req_mask;
  logic      b_rd_pend;
  scr_word_t b_mem_data;

  port_request_stage u_a_request (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .v_i       (a_v_i),
    .w_i       (a_w_i),
    .addr_i    (a_addr_i),
    .data_i    (a_data_i),
    .w_mask_i  (a_w_mask_i),
    .v_o       (a_req_v),
    .w_o       (a_req_w),
    .addr_o    (a_req_addr),
    .data_o    (a_req_data),
    .w_mask_o  (a_req_mask),
    .rd_pend_o (a_rd_pend)
  );

  port_request_stage u_b_request (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .v_i       (b_v_i),
    .w_i       (b_w_i),
    .addr_i    (b_addr_i),
    .data_i    (b_data_i),
    .w_mask_i  (b_w_mask_i),
    .v_o       (b_req_v),
    .w_o       (b_req_w),
    .addr_o    (b_req_addr),
    .data_o    (b_req_data),
    .w_mask_o  (b_req_mask),
    .rd_pend_o (b_rd_pend)
  );

  mem_2rw_sync_mask_write_bit u_mem (
    .clk_i      (clk_i),
    .a_v_i      (a_req_v),
    .a_w_i      (a_req_w),
    .a_addr_i   (a_req_addr),
    .a_data_i   (a_req_data),
    .a_w_mask_i (a_req_mask),
    .a_data_o   (a_mem_data),
    .b_v_i      (b_req_v),
    .b_w_i      (b_req_w),
    .b_addr_i   (b_req_addr),
    .b_data_i   (b_req_data),
    .b_w_mask_i (b_req_mask),
    .b_data_o   (b_mem_data)
  );

  read_response_stage u_a_response (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_pend_i (a_rd_pend),
    .rd_data_i (a_mem_data),
    .rd_v_o    (a_rd_v_o),
    .rd_data_o (a_rd_data_o)
  );

  read_response_stage u_b_response (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_pend_i (b_rd_pend),
    .rd_data_i (b_mem_data),
    .rd_v_o    (b_rd_v_o),
    .rd_data_o (b_rd_data_o)
  );

endmodule

`default_nettype wire

//--- testbench/scratchpad_2rw_tb.sv
`default_nettype none

`include "scratch_params.svh"

module scratchpad_2rw_tb
  import scratch_pkg::*;
();

  localparam int timeout_lc = 2000; // Run takes about 330 cycles

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      a_v_i;
  logic      a_w_i;
  logic      b_v_i;
  logic      b_w_i;
  scr_addr_t a_addr_i;
  scr_addr_t b_addr_i;
  scr_word_t a_data_i;
  scr_word_t b_data_i;
  scr_mask_t a_w_mask_i;
  scr_mask_t b_w_mask_i;
  logic      a_rd_v_o;
  logic      b_rd_v_o;
  scr_word_t a_rd_data_o;
  scr_word_t b_rd_data_o;

  scr_word_t shadow [`SCR_ELS_P]; // Reference copy of the array
  scr_word_t a_exp_q [$];
  scr_word_t b_exp_q [$];
  int        a_iss_q [$]; // Edge index at which each read was driven
  int        b_iss_q [$];
  integer    seed;
  int        errors;
  int        cycles;
  string     test_name;

  scratchpad_2rw_top u_scratchpad_2rw_top (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeout_lc)
    begin
      $display("timeout: run did not finish within %0d cycles", timeout_lc);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare_read(input string port, input scr_word_t exp_val, input scr_word_t act);
    assert (act === exp_val)
    else
    begin
      errors++;
      $display("mismatch %s port %s: expected %h actual %h", test_name, port, exp_val, act);
    end
  endtask

  task automatic check_latency(input string port, input int issued);
    assert (cycles - issued == 3)
    else
    begin
      errors++;
      $display("mismatch %s port %s latency: expected %0d actual %0d", test_name, port, 3,
               cycles - issued);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i)
  begin
    if (arst_n_i && a_rd_v_o)
    begin
      assert (a_exp_q.size() != 0)
      else
      begin
        errors++;
        $display("%s: port A gave read data with no read outstanding", test_name);
      end
      if (a_exp_q.size() != 0)
      begin
        compare_read("A", a_exp_q.pop_front(), a_rd_data_o);
        check_latency("A", a_iss_q.pop_front());
      end
    end
    if (arst_n_i && b_rd_v_o)
    begin
      assert (b_exp_q.size() != 0)
      else
      begin
        errors++;
        $display("%s: port B gave read data with no read outstanding", test_name);
      end
      if (b_exp_q.size() != 0)
      begin
        compare_read("B", b_exp_q.pop_front(), b_rd_data_o);
        check_latency("B", b_iss_q.pop_front());
      end
    end
  end

  function automatic scr_word_t merge_bits(scr_word_t old, scr_word_t data, scr_mask_t mask);
    return (old & ~mask) | (data & mask);
  endfunction

  // Reads are queued from the shadow before this cycle's writes
  task automatic drive_ports(input logic av, input logic aw, input scr_addr_t aaddr,
                             input scr_word_t adata, input scr_mask_t amask,
                             input logic bv, input logic bw, input scr_addr_t baddr,
                             input scr_word_t bdata, input scr_mask_t bmask);
    @(posedge clk_i);
    a_v_i      <= av;
    a_w_i      <= aw;
    a_addr_i   <= aaddr;
    a_data_i   <= adata;
    a_w_mask_i <= amask;
    b_v_i      <= bv;
    b_w_i      <= bw;
    b_addr_i   <= baddr;
    b_data_i   <= bdata;
    b_w_mask_i <= bmask;
    if (av && !aw)
    begin
      a_exp_q.push_back(shadow[aaddr]);
      a_iss_q.push_back(cycles + 1); // Counter still holds the previous edge
    end
    if (bv && !bw)
    begin
      b_exp_q.push_back(shadow[baddr]);
      b_iss_q.push_back(cycles + 1);
    end
    if (av && aw)
      shadow[aaddr] = merge_bits(shadow[aaddr], adata, amask);
    if (bv && bw)
      shadow[baddr] = merge_bits(shadow[baddr], bdata, bmask); // B goes last and wins the overlap
  endtask

  task automatic wait_drained();
    drive_ports(0, 0, '0, '0, '0, 0, 0, '0, '0, '0);
    while (a_exp_q.size() != 0 || b_exp_q.size() != 0)
      @(posedge clk_i);
    repeat (2) @(posedge clk_i); // Catch stray read valids
  endtask

  task automatic check_idle_outputs();
    @(negedge clk_i);
    assert (!a_rd_v_o && !b_rd_v_o)
    else
    begin
      errors++;
      $display("%s: read valid high around reset", test_name);
    end
    assert (a_rd_data_o === '0 && b_rd_data_o === '0)
    else
    begin
      errors++;
      $display("mismatch %s: expected %h actual %h %h", test_name, 32'h0, a_rd_data_o,
               b_rd_data_o);
    end
  endtask

  task automatic reset_sequence();
    test_name = "reset";
    repeat (4) check_idle_outputs();
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (2) check_idle_outputs();
  endtask

  task automatic round_trip_all_words();
    test_name = "round_trip";
    for (int i = 0; i < `SCR_ELS_P / 2; i++)
      drive_ports(1, 1, scr_addr_t'(i), $random(seed), '1,
                  1, 1, scr_addr_t'(i + `SCR_ELS_P / 2), $random(seed), '1);
    for (int i = 0; i < `SCR_ELS_P; i++)
      drive_ports(1, 0, scr_addr_t'(i), '0, '0, 1, 0, scr_addr_t'(`SCR_ELS_P - 1 - i), '0, '0);
    wait_drained();
  endtask

  task automatic partial_mask_writes();
    scr_addr_t addr;
    scr_addr_t addr2;
    test_name = "partial_masks";
    for (int i = 0; i < 24; i++)
    begin
      addr  = scr_addr_t'($random(seed));
      addr2 = scr_addr_t'($random(seed));
      drive_ports(1, 1, addr, $random(seed), $random(seed), 0, 0, '0, '0, '0);
      drive_ports(1, 0, addr, '0, '0, 1, 1, addr2, $random(seed), '0); // B write changes nothing
      drive_ports(0, 0, '0, '0, '0, 1, 0, addr2, '0, '0);
    end
    wait_drained();
  endtask

  task automatic dual_port_access();
    scr_addr_t x;
    scr_addr_t y;
    test_name = "dual_port";
    for (int i = 0; i < 8; i++)
    begin
      x = scr_addr_t'($random(seed));
      y = x ^ scr_addr_t'(1);
      drive_ports(1, 1, x, $random(seed), '1, 1, 1, y, $random(seed), '1);
      drive_ports(1, 0, y, '0, '0, 1, 0, x, '0, '0);
    end
    wait_drained();
  endtask

  task automatic write_collision();
    scr_addr_t addr;
    test_name = "collision";
    for (int i = 0; i < 8; i++)
    begin
      addr = scr_addr_t'($random(seed));
      drive_ports(1, 1, addr, $random(seed), $random(seed) | 32'h00ff_ff00,
                  1, 1, addr, $random(seed), $random(seed) | 32'h0ff0_0ff0);
      drive_ports(1, 0, addr, '0, '0, 1, 0, addr, '0, '0);
    end
    wait_drained();
  endtask

  task automatic read_during_write();
    scr_addr_t addr;
    test_name = "read_during_write";
    for (int i = 0; i < 8; i++)
    begin
      addr = scr_addr_t'($random(seed));
      drive_ports(1, 0, addr, '0, '0, 1, 1, addr, $random(seed), '1); // A sees old word
      drive_ports(1, 0, addr, '0, '0, 0, 0, '0, '0, '0);
    end
    wait_drained();
  endtask

  initial
  begin
    seed       = 32'h7faee830;
    errors     = 0;
    cycles     = 0;
    arst_n_i   = 1'b0;
    a_v_i      = 1'b0;
    a_w_i      = 1'b0;
    a_addr_i   = '0;
    a_data_i   = '0;
    a_w_mask_i = '0;
    b_v_i      = 1'b0;
    b_w_i      = 1'b0;
    b_addr_i   = '0;
    b_data_i   = '0;
    b_w_mask_i = '0;
    reset_sequence();
    round_trip_all_words();
    partial_mask_writes();
    dual_port_access();
    write_collision();
    read_during_write();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
